// File: filelist.f
+incdir+hw
hw/gfx_pkg.sv
hw/uart_rx.sv
hw/cmd_assembler.sv
hw/draw_engine.sv
hw/frame_store.sv
hw/display_timings.sv
hw/pixel_output.sv
hw/gfx_top.sv
test/gfx_assert.sv
test/tb_gfx.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_gfx
FILELIST = filelist.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_gfx.sv
//--------------------------------------------------------------------------
// tb_gfx: directed tests from the serial command port to the RGB output
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module tb_gfx;

    localparam int CPB   = `GFX_UART_CLKS_PER_BIT;
    localparam int LINE  = `GFX_H_ACTIVE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
    localparam int FRAME = LINE * (`GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK);
    localparam gfx_pkg::rgb444_t GREY = 12'h222;

    logic             clk_pix, reset, rx, hsync, vsync, de;
    gfx_pkg::rgb444_t rgb;
    gfx_pkg::rgb444_t screen [`GFX_V_ACTIVE][`GFX_H_ACTIVE];
    gfx_pkg::rgb444_t fb_model [`GFX_FB_HEIGHT][`GFX_FB_WIDTH];
    int               seed = 58;
    int               cur_x = 0, cur_y = 0;
    bit               fail_seen = 1'b0, run_done = 1'b0;

    gfx_top uut (
        .clk_pix(clk_pix), .reset(reset), .rx_i(rx),
        .rgb_o(rgb), .hsync_o(hsync), .vsync_o(vsync), .de_o(de)
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        fail_seen = 1'b1;
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_rgb(input int x, input int y, input gfx_pkg::rgb444_t got,
                               input gfx_pkg::rgb444_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch rgb_o at x=%0d y=%0d: got %h expected %h",
                                    x, y, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx <= bits[i];
            repeat (CPB) @(posedge clk_pix);
        end
    endtask

    // idle afterwards so a 256 pixel run is done before the next word
    task automatic send_cmd(input gfx_pkg::cmd_word_t cmd);
        @(posedge clk_pix);
        for (int i = 3; i >= 0; i--) begin
            send_byte(cmd[8*i +: 8]);
        end
        repeat (2 * CPB) @(posedge clk_pix);
    endtask

    task automatic set_pos(input int x, input int y);
        gfx_pkg::cmd_word_t cmd;
        cmd.pos = '{gfx_pkg::OP_SET_POS, 12'(x), 12'(y)};
        send_cmd(cmd);
        cur_x = x % `GFX_FB_WIDTH;
        cur_y = y % `GFX_FB_HEIGHT;
    endtask

    // model cursor wraps at line end and at frame end
    task automatic write_run(input int n, input gfx_pkg::rgb444_t color);
        gfx_pkg::cmd_word_t cmd;
        cmd.pix = '{gfx_pkg::OP_WRITE_PIXEL, 8'(n - 1), 4'h0, color};
        send_cmd(cmd);
        for (int i = 0; i < n; i++) begin
            fb_model[cur_y][cur_x] = color;
            cur_x = (cur_x + 1) % `GFX_FB_WIDTH;
            if (cur_x == 0) begin
                cur_y = (cur_y + 1) % `GFX_FB_HEIGHT;
            end
        end
    endtask

    function automatic gfx_pkg::rgb444_t rand_color();
        return gfx_pkg::rgb444_t'(12'($random(seed)));
    endfunction

    task automatic wait_vsync_fall(input bit de_low);
        int t;
        bit seen_high;
        t = 0;
        seen_high = 1'b0;
        do begin
            @(negedge clk_pix);
            if (de_low) begin
                compare_bit("de_o", de, 1'b0);
            end
            seen_high |= vsync;
            t++;
            if (t > 2 * FRAME) stop_on_error("timeout waiting for vsync_o to fall");
        end while (vsync || !seen_high);
    endtask

    // blanking must be black, and no active line may follow line 479
    task automatic capture_frame();
        int t;
        wait_vsync_fall(1'b0);
        for (int ln = 0; ln < `GFX_V_ACTIVE; ln++) begin
            t = 0;
            while (!de) begin
                compare_rgb(-1, ln, rgb, '0);
                t++;
                if (t > 40 * LINE) stop_on_error("timeout waiting for de_o");
                @(negedge clk_pix);
            end
            for (int col = 0; col < `GFX_H_ACTIVE; col++) begin
                compare_bit("de_o", de, 1'b1);
                compare_bit("hsync_o", hsync, 1'b1);
                screen[ln][col] = rgb;
                @(negedge clk_pix);
            end
            compare_bit("de_o", de, 1'b0);
        end
        wait_vsync_fall(1'b1);
    endtask

    task automatic check_screen(input bit fb_written);
        for (int y = 0; y < `GFX_V_ACTIVE; y++) begin
            for (int x = 0; x < `GFX_H_ACTIVE; x++) begin
                if (x >= `GFX_FB_WIDTH || y >= `GFX_FB_HEIGHT) begin
                    compare_rgb(x, y, screen[y][x], GREY);
                end else if (fb_written) begin
                    compare_rgb(x, y, screen[y][x], fb_model[y][x]);
                end
            end
        end
    endtask

    task automatic test_reset_blanking();
        repeat (7) @(posedge clk_pix);
        @(negedge clk_pix);
        compare_bit("hsync_o", hsync, 1'b1);
        compare_bit("vsync_o", vsync, 1'b1);
        compare_bit("de_o", de, 1'b0);
        compare_rgb(0, 0, rgb, '0);
        @(posedge clk_pix);
        reset <= 1'b0;
        capture_frame();
    endtask

    task automatic test_border();
        check_screen(1'b0);
    endtask

    task automatic test_single_write();
        int x, y;
        gfx_pkg::rgb444_t c;
        // frame store has no reset, so write all of it first
        set_pos(0, 0);
        for (int i = 0; i < 8; i++) begin
            write_run(256, rand_color());
        end
        x = {$random(seed)} % `GFX_FB_WIDTH;
        y = {$random(seed)} % `GFX_FB_HEIGHT;
        c = rand_color();
        set_pos(x, y);
        write_run(1, c);
        capture_frame();
        compare_rgb(x, y, screen[y][x], c);
        check_screen(1'b1);
    endtask

    task automatic test_run_wrap();
        set_pos(54, 12);
        write_run(20, rand_color());
        // last line wraps to the top
        set_pos(60, 31);
        write_run(8, rand_color());
        capture_frame();
        check_screen(1'b1);
    endtask

    task automatic test_decode();
        gfx_pkg::cmd_word_t cmd;
        cmd = 32'h0312_0ABC;
        send_cmd(cmd);
        set_pos(70, 35);
        write_run(1, rand_color());
        write_run(3, rand_color());
        capture_frame();
        check_screen(1'b1);
    endtask

    initial begin
        reset = 1'b1;
        rx    = 1'b1;
        test_reset_blanking();
        test_border();
        test_single_write();
        test_run_wrap();
        test_decode();
        run_done = 1'b1;
        $display("TESTBENCH PASSED");
        $finish;
    end

    // a failing assertion ends the run early
    final begin
        if (!run_done && !fail_seen) begin
            $display("TESTBENCH FAILED");
        end
    end

endmodule

// File: test/gfx_assert.sv
//--------------------------------------------------------------------------
// gfx_assert: draw engine and output alignment checks
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module gfx_assert (
    input logic                          clk_pix,
    input logic                          reset,
    input logic                          cmd_valid_i,
    input logic                          wr_en_i,
    input logic [gfx_pkg::FB_ADDR_W-1:0] wr_addr_i,
    input logic                          hsync_i,
    input logic                          vsync_i,
    input logic                          de_i
);

    // no back-pressure, so a command during a run is lost
    assert property (@(posedge clk_pix) disable iff (reset) wr_en_i |-> !cmd_valid_i)
        else $error("command arrived during an active pixel run");

    // a run steps one address per write, wrapping at the end of the store
    assert property (@(posedge clk_pix) disable iff (reset)
        wr_en_i && $past(wr_en_i) |-> wr_addr_i == $past(wr_addr_i) + 1'b1)
        else $error("write address did not advance by one during a run");

    assert property (@(posedge clk_pix) disable iff (reset) de_i |-> hsync_i && vsync_i)
        else $error("de_o high while a sync is active");

endmodule

bind draw_engine gfx_assert u_engine_assert (
    .clk_pix(clk_pix), .reset(reset), .cmd_valid_i(cmd_valid_i),
    .wr_en_i(wr_en_o), .wr_addr_i(wr_addr_o),
    .hsync_i(1'b1), .vsync_i(1'b1), .de_i(1'b0)
);

bind pixel_output gfx_assert u_output_assert (
    .clk_pix(clk_pix), .reset(reset), .cmd_valid_i(1'b0),
    .wr_en_i(1'b0), .wr_addr_i('0),
    .hsync_i(hsync_o), .vsync_i(vsync_o), .de_i(de_o)
);

// File: hw/gfx_top.sv
//--------------------------------------------------------------------------
// gfx_top: serial commands in, framebuffer drawing, 480p RGB out
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module gfx_top (
    input  logic             clk_pix,
    input  logic             reset,
    input  logic             rx_i,
    output gfx_pkg::rgb444_t rgb_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o
);

    logic [7:0]                      rx_byte;
    logic                            rx_valid;
    gfx_pkg::cmd_word_t              cmd_word;
    logic                            cmd_valid;
    logic                            wr_en;
    logic [gfx_pkg::FB_ADDR_W-1:0]   wr_addr;
    gfx_pkg::rgb444_t                wr_color;
    logic [gfx_pkg::FB_ADDR_W-1:0]   rd_addr;
    gfx_pkg::rgb444_t                rd_color;
    logic signed [15:0]              sx, sy;
    logic                            hsync, vsync, de, frame, line;

    uart_rx u_uart_rx (
        .clk_pix(clk_pix), .reset(reset), .rx_i(rx_i),
        .byte_o(rx_byte), .valid_o(rx_valid)
    );

    cmd_assembler u_cmd_assembler (
        .clk_pix(clk_pix), .reset(reset),
        .byte_i(rx_byte), .byte_valid_i(rx_valid),
        .cmd_o(cmd_word), .cmd_valid_o(cmd_valid)
    );

    draw_engine u_draw_engine (
        .clk_pix(clk_pix), .reset(reset),
        .cmd_i(cmd_word), .cmd_valid_i(cmd_valid),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_color_o(wr_color)
    );

    frame_store u_frame_store (
        .clk_pix(clk_pix),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_color_i(wr_color),
        .rd_addr_i(rd_addr), .rd_color_o(rd_color)
    );

    display_timings u_display_timings (
        .clk_pix(clk_pix), .reset(reset), .sx_o(sx), .sy_o(sy),
        .hsync_o(hsync), .vsync_o(vsync), .de_o(de),
        .frame_o(frame), .line_o(line)
    );

    pixel_output u_pixel_output (
        .clk_pix(clk_pix), .reset(reset), .sx_i(sx), .sy_i(sy),
        .hsync_i(hsync), .vsync_i(vsync), .de_i(de),
        .rd_addr_o(rd_addr), .rd_color_i(rd_color),
        .rgb_o(rgb_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o)
    );

endmodule

// File: hw/pixel_output.sv
//--------------------------------------------------------------------------
// pixel_output: framebuffer fetch, border and blanking, sync alignment
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module pixel_output (
    input  logic                            clk_pix,
    input  logic                            reset,
    input  logic signed [15:0]              sx_i,
    input  logic signed [15:0]              sy_i,
    input  logic                            hsync_i,
    input  logic                            vsync_i,
    input  logic                            de_i,
    output logic [gfx_pkg::FB_ADDR_W-1:0]   rd_addr_o,
    input  gfx_pkg::rgb444_t                rd_color_i,
    output gfx_pkg::rgb444_t                rgb_o,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            de_o
);

    localparam int ADDR_W = gfx_pkg::FB_ADDR_W;

    logic hsync_d1, vsync_d1, de_d1, inside_d1;

    // only meaningful inside the framebuffer area
    assign rd_addr_o = ADDR_W'(int'(sy_i) * `GFX_FB_WIDTH + int'(sx_i));

    // stage 1, read in flight
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_d1  <= 1'b1;
            vsync_d1  <= 1'b1;
            de_d1     <= 1'b0;
            inside_d1 <= 1'b0;
        end else begin
            hsync_d1  <= hsync_i;
            vsync_d1  <= vsync_i;
            de_d1     <= de_i;
            inside_d1 <= sx_i < `GFX_FB_WIDTH && sy_i < `GFX_FB_HEIGHT;
        end
    end

    // stage 2, colour select
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
            rgb_o   <= '0;
        end else begin
            hsync_o <= hsync_d1;
            vsync_o <= vsync_d1;
            de_o    <= de_d1;
            if (!de_d1) begin
                rgb_o <= '0;
            end else if (inside_d1) begin
                rgb_o <= rd_color_i;
            end else begin
                rgb_o <= '{r: 4'h2, g: 4'h2, b: 4'h2};
            end
        end
    end

endmodule

// File: hw/display_timings.sv
//--------------------------------------------------------------------------
// display_timings: 640x480 scan counters, syncs, data enable and strobes
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module display_timings (
    input  logic               clk_pix,
    input  logic               reset,
    output logic signed [15:0] sx_o,
    output logic signed [15:0] sy_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,
    output logic               frame_o,
    output logic               line_o
);

    localparam int H_SYNC_START = `GFX_H_ACTIVE + `GFX_H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `GFX_H_SYNC;
    localparam int H_TOTAL      = H_SYNC_END + `GFX_H_BACK;
    localparam int V_SYNC_START = `GFX_V_ACTIVE + `GFX_V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `GFX_V_SYNC;
    localparam int V_TOTAL      = V_SYNC_END + `GFX_V_BACK;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx_o <= '0;
            sy_o <= '0;
        end else if (sx_o == 16'(H_TOTAL - 1)) begin
            sx_o <= '0;
            sy_o <= (sy_o == 16'(V_TOTAL - 1)) ? 16'sd0 : sy_o + 16'sd1;
        end else begin
            sx_o <= sx_o + 16'sd1;
        end
    end

    // negative polarity syncs
    assign hsync_o = !(sx_o >= H_SYNC_START && sx_o < H_SYNC_END);
    assign vsync_o = !(sy_o >= V_SYNC_START && sy_o < V_SYNC_END);
    assign de_o    = sx_o < `GFX_H_ACTIVE && sy_o < `GFX_V_ACTIVE;

    assign frame_o = sx_o == 16'sd0 && sy_o == 16'sd0;
    assign line_o  = sx_o == 16'sd0;

endmodule

// File: hw/frame_store.sv
//--------------------------------------------------------------------------
// frame_store: on-chip framebuffer, one write port, registered read port
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module frame_store (
    input  logic                            clk_pix,
    input  logic                            wr_en_i,
    input  logic [gfx_pkg::FB_ADDR_W-1:0]   wr_addr_i,
    input  gfx_pkg::rgb444_t                wr_color_i,
    input  logic [gfx_pkg::FB_ADDR_W-1:0]   rd_addr_i,
    output gfx_pkg::rgb444_t                rd_color_o
);

    localparam int DEPTH = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;

    gfx_pkg::rgb444_t mem [DEPTH];

    always_ff @(posedge clk_pix) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_color_i;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk_pix) begin
        rd_color_o <= mem[rd_addr_i];
    end

endmodule

// File: hw/draw_engine.sv
//--------------------------------------------------------------------------
// draw_engine: decodes commands, keeps the cursor, writes pixel runs
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module draw_engine (
    input  logic                            clk_pix,
    input  logic                            reset,
    input  gfx_pkg::cmd_word_t              cmd_i,
    input  logic                            cmd_valid_i,
    output logic                            wr_en_o,
    output logic [gfx_pkg::FB_ADDR_W-1:0]   wr_addr_o,
    output gfx_pkg::rgb444_t                wr_color_o
);

    localparam int ADDR_W = gfx_pkg::FB_ADDR_W;
    localparam int X_W    = $clog2(`GFX_FB_WIDTH);
    localparam int Y_W    = $clog2(`GFX_FB_HEIGHT);

    logic [X_W-1:0]   cur_x;
    logic [Y_W-1:0]   cur_y;
    logic             run_active;
    logic [7:0]       run_left;
    gfx_pkg::rgb444_t run_color;

    assign wr_en_o    = run_active;
    assign wr_addr_o  = ADDR_W'(int'(cur_y) * `GFX_FB_WIDTH + int'(cur_x));
    assign wr_color_o = run_color;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            cur_x      <= '0;
            cur_y      <= '0;
            run_active <= 1'b0;
            run_left   <= '0;
        end else if (run_active) begin
            // step along the line, wrap to next line and then to the top
            if (cur_x == X_W'(`GFX_FB_WIDTH - 1)) begin
                cur_x <= '0;
                if (cur_y == Y_W'(`GFX_FB_HEIGHT - 1)) begin
                    cur_y <= '0;
                end else begin
                    cur_y <= cur_y + 1'b1;
                end
            end else begin
                cur_x <= cur_x + 1'b1;
            end
            run_left <= run_left - 1'b1;
            if (run_left == 8'd0) begin
                run_active <= 1'b0;
            end
        end else if (cmd_valid_i) begin
            case (cmd_i.pos.opcode)
                gfx_pkg::OP_SET_POS: begin
                    cur_x <= X_W'(cmd_i.pos.x % 12'(`GFX_FB_WIDTH));
                    cur_y <= Y_W'(cmd_i.pos.y % 12'(`GFX_FB_HEIGHT));
                end
                gfx_pkg::OP_WRITE_PIXEL: begin
                    run_active <= 1'b1;
                    run_left   <= cmd_i.pix.count;
                end
                default: ;
            endcase
        end
    end

    // colour latched when a run starts
    always_ff @(posedge clk_pix) begin
        if (!run_active && cmd_valid_i && cmd_i.pix.opcode == gfx_pkg::OP_WRITE_PIXEL) begin
            run_color <= cmd_i.pix.color;
        end
    end

endmodule

// File: hw/cmd_assembler.sv
//--------------------------------------------------------------------------
// cmd_assembler: packs four serial bytes, msb first, into a command word
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module cmd_assembler (
    input  logic                clk_pix,
    input  logic                reset,
    input  logic [7:0]          byte_i,
    input  logic                byte_valid_i,
    output gfx_pkg::cmd_word_t  cmd_o,
    output logic                cmd_valid_o
);

    logic [1:0]  byte_cnt;
    logic [31:0] word_q;

    assign cmd_o = word_q;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            byte_cnt    <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (byte_valid_i) begin
                // wraps back to zero after the fourth byte
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) begin
                    cmd_valid_o <= 1'b1;
                end
            end
        end
    end

    // first byte ends up in the top of the word
    always_ff @(posedge clk_pix) begin
        if (byte_valid_i) begin
            word_q <= {word_q[23:0], byte_i};
        end
    end

endmodule

// File: hw/uart_rx.sv
//--------------------------------------------------------------------------
// uart_rx: 8N1 serial receiver, one-cycle valid strobe per good byte
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "gfx_settings.svh"

module uart_rx (
    input  logic       clk_pix,
    input  logic       reset,
    input  logic       rx_i,
    output logic [7:0] byte_o,
    output logic       valid_o
);

    localparam int CPB   = `GFX_UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);

    typedef enum logic [1:0] { S_IDLE, S_START, S_DATA, S_STOP } state_t;

    state_t           state;
    logic             rx_meta, rx_sync, rx_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    assign byte_o = shift_q;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            valid_o <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    // half a bit in, start bit must still be low
                    if (clk_cnt == CNT_W'(CPB / 2 - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (clk_cnt == CNT_W'(CPB - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                S_STOP: begin
                    if (clk_cnt == CNT_W'(CPB - 1)) begin
                        // framing error drops the byte
                        valid_o <= rx_sync;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_pix) begin
        if (state == S_DATA && clk_cnt == CNT_W'(CPB - 1)) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

endmodule

// File: hw/gfx_pkg.sv
//--------------------------------------------------------------------------
// gfx package: colour type, command opcodes and command word views
//--------------------------------------------------------------------------
`include "gfx_settings.svh"

package gfx_pkg;

    localparam int FB_ADDR_W = $clog2(`GFX_FB_WIDTH * `GFX_FB_HEIGHT);

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    typedef enum logic [7:0] {
        OP_SET_POS     = 8'h01,
        OP_WRITE_PIXEL = 8'h02
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] x;
        logic [11:0] y;
    } cmd_pos_t;

    // count holds run length minus one
    typedef struct packed {
        opcode_t    opcode;
        logic [7:0] count;
        logic [3:0] unused;
        rgb444_t    color;
    } cmd_pix_t;

    typedef union packed {
        cmd_pos_t pos;
        cmd_pix_t pix;
    } cmd_word_t;

endpackage

// File: hw/gfx_settings.svh
//--------------------------------------------------------------------------
// gfx settings: display timing, framebuffer size and serial bit period
//--------------------------------------------------------------------------
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// framebuffer size in pixels
`define GFX_FB_WIDTH  64
`define GFX_FB_HEIGHT 32

// 480p horizontal timing
`define GFX_H_ACTIVE 640
`define GFX_H_FRONT  16
`define GFX_H_SYNC   96
`define GFX_H_BACK   48

// 480p vertical timing
`define GFX_V_ACTIVE 480
`define GFX_V_FRONT  10
`define GFX_V_SYNC   2
`define GFX_V_BACK   33

// 25 MHz pixel clock at 115200 baud
`define GFX_UART_CLKS_PER_BIT 217

`endif
